/* src/vldu_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Vector load unit shared definitions
// Widths, queue depths, element widths and the structs passed
// between the instruction queue, the beat unpacker and the lanes
//////////////////////////////////////////////////////////////////////

`default_nettype none

package vldu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Lanes of the register file
  localparam int unsigned NrLanes          = 2;
  localparam int unsigned LaneBytes        = 8;
  // One VRF word spans all lanes
  localparam int unsigned WordBytes        = NrLanes * LaneBytes;
  // Bytes carried by one R beat
  localparam int unsigned BeatBytes        = 8;
  localparam int unsigned InsnQueueDepth   = 4;
  localparam int unsigned ResultQueueDepth = 2;
  // Lane words per vector register
  localparam int unsigned VRegWords        = 8;

  // Derived widths
  localparam int unsigned InsnPtrW  = $clog2(InsnQueueDepth);
  localparam int unsigned InsnCntW  = InsnPtrW + 1;
  localparam int unsigned ResPtrW   = $clog2(ResultQueueDepth);
  localparam int unsigned ResCntW   = ResPtrW + 1;
  localparam int unsigned WordPosW  = $clog2(WordBytes);
  localparam int unsigned BeatCntW  = $clog2(BeatBytes) + 1;
  localparam int unsigned WordIdxW  = $clog2(VRegWords);
  localparam int unsigned LaneSelW  = $clog2(NrLanes);
  localparam int unsigned LaneByteW = $clog2(LaneBytes);

  //////////////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////////////

  typedef logic [2:0]             vid_t;
  typedef logic [4:0]             vreg_t;
  // Element count, also used for byte counts up to 128
  typedef logic [7:0]             vlen_t;
  typedef logic [7:0]             vaddr_t;
  typedef logic [8*LaneBytes-1:0] elen_t;
  typedef logic [LaneBytes-1:0]   strb_t;
  typedef logic [8*BeatBytes-1:0] beat_t;

  // Element width, the value is log2 of the element size in bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  // Load instruction as offered to the unit
  typedef struct packed {
    vid_t  id;
    vreg_t vd;
    vew_e  vew;
    vlen_t vl;
  } load_insn_t;

  // Write request towards one lane
  typedef struct packed {
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_req_t;

  // Complete VRF word, one request per lane
  typedef struct packed {
    vid_t                    id;
    logic                    last;
    lane_req_t [NrLanes-1:0] lanes;
  } result_word_t;

endpackage

`default_nettype wire

/* src/vldu_insn_queue.sv */
//////////////////////////////////////////////////////////////////////
// Load instruction queue
// Ring of in-flight loads with accept and issue pointers and
// issue and commit counts
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vldu_insn_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Instruction request
  input  vldu_pkg::load_insn_t insn_i,
  input  logic                 insn_valid_i,
  output logic                 insn_ready_o,
  // Towards the beat unpacker
  output vldu_pkg::load_insn_t issue_insn_o,
  output logic                 issue_valid_o,
  input  logic                 issue_done_i,
  // From the result queue
  input  logic                 retire_last_i
);

  import vldu_pkg::*;

  // Instruction storage
  load_insn_t [InsnQueueDepth-1:0] insn_q;

  // Write slot and oldest unissued entry
  logic [InsnPtrW-1:0] accept_pnt_q;
  logic [InsnPtrW-1:0] issue_pnt_q;

  // Entries waiting for issue and for commit
  logic [InsnCntW-1:0] issue_cnt_q;
  logic [InsnCntW-1:0] commit_cnt_q;

  logic accept;

  // Entries stay held until their last word has retired
  assign insn_ready_o = (commit_cnt_q != InsnCntW'(InsnQueueDepth));
  assign accept       = insn_valid_i && insn_ready_o;

  // Oldest unissued instruction
  assign issue_valid_o = (issue_cnt_q != '0);
  assign issue_insn_o  = insn_q[issue_pnt_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
    end else begin
      // Pointers wrap on their own, depth is a power of two
      if (accept)
        accept_pnt_q <= accept_pnt_q + 1'b1;
      if (issue_done_i)
        issue_pnt_q <= issue_pnt_q + 1'b1;
      // Accept and issue or commit may land in one cycle
      issue_cnt_q  <= issue_cnt_q + InsnCntW'(accept) - InsnCntW'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + InsnCntW'(accept) - InsnCntW'(retire_last_i);
    end
  end

  // Payload only
  always_ff @(posedge clk_i) begin
    if (accept)
      insn_q[accept_pnt_q] <= insn_i;
  end

endmodule

`default_nettype wire

/* src/vldu_beat_unpack.sv */
//////////////////////////////////////////////////////////////////////
// R beat unpacker
// Cuts memory beats into VRF words and spreads the bytes over
// the lanes according to the element width
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vldu_beat_unpack (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Instruction being issued
  input  vldu_pkg::load_insn_t   issue_insn_i,
  input  logic                   issue_valid_i,
  output logic                   issue_done_o,
  // R channel
  input  vldu_pkg::beat_t        r_data_i,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  // Towards the result queue
  input  logic                   full_i,
  output logic                   push_o,
  output vldu_pkg::result_word_t push_word_o
);

  import vldu_pkg::*;

  // Control state
  logic                active_q;
  vlen_t               rem_q;
  logic [WordPosW-1:0] wpos_q;
  logic [WordIdxW-1:0] widx_q;

  // Assembly register of the current word
  elen_t [NrLanes-1:0] data_q, data_d;
  strb_t [NrLanes-1:0] be_q, be_d;

  logic [BeatCntW-1:0] n_bytes;
  logic [WordPosW:0]   wpos_sum;
  logic                last_beat;
  logic                word_done;
  logic                consume;
  vaddr_t              word_addr;

  //////////////////////////////////////////////////////////////////////
  // Beat accounting
  //////////////////////////////////////////////////////////////////////

  // Beat ends early once the instruction runs out of bytes
  assign last_beat = (rem_q <= vlen_t'(BeatBytes));
  assign n_bytes   = last_beat ? BeatCntW'(rem_q) : BeatCntW'(BeatBytes);
  assign wpos_sum  = wpos_q + n_bytes;
  assign word_done = (wpos_sum == WordBytes) || last_beat;

  // Hold the beat only when it would need a full result queue
  assign r_ready_o    = active_q && (!word_done || !full_i);
  assign consume      = r_valid_i && r_ready_o;
  assign push_o       = consume && word_done;
  assign issue_done_o = push_o && last_beat;

  // Destination word inside vd
  assign word_addr = vaddr_t'(issue_insn_i.vd) * vaddr_t'(VRegWords) + vaddr_t'(widx_q);

  //////////////////////////////////////////////////////////////////////
  // Byte shuffle
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_place
    logic [WordPosW-1:0]  byte_idx;
    logic [WordPosW-1:0]  elem;
    logic [WordPosW-1:0]  emask;
    logic [LaneSelW-1:0]  lane_sel;
    logic [LaneByteW-1:0] lane_byte;

    // A fresh word starts cleared, tail bytes stay zero
    data_d = (wpos_q == '0) ? '0 : data_q;
    be_d   = (wpos_q == '0) ? '0 : be_q;
    emask  = (WordPosW'(1) << issue_insn_i.vew) - 1'b1;

    for (int k = 0; k < BeatBytes; k++) begin
      // Stream byte index within the VRF word
      byte_idx  = wpos_q + WordPosW'(k);
      elem      = byte_idx >> issue_insn_i.vew;
      // Elements alternate over the lanes
      lane_sel  = LaneSelW'(elem % NrLanes);
      lane_byte = LaneByteW'(((elem / NrLanes) << issue_insn_i.vew) | (byte_idx & emask));
      if (k < n_bytes) begin
        data_d[lane_sel][8*lane_byte +: 8] = r_data_i[8*k +: 8];
        be_d[lane_sel][lane_byte]          = 1'b1;
      end
    end
  end

  // Word handed over in the cycle of its completing beat
  always_comb begin
    push_word_o.id   = issue_insn_i.id;
    push_word_o.last = last_beat;
    for (int l = 0; l < NrLanes; l++) begin
      push_word_o.lanes[l].addr  = word_addr;
      push_word_o.lanes[l].wdata = data_d[l];
      push_word_o.lanes[l].be    = be_d[l];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // State
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      rem_q    <= '0;
      wpos_q   <= '0;
      widx_q   <= '0;
    end else if (consume) begin
      rem_q  <= rem_q - vlen_t'(n_bytes);
      wpos_q <= word_done ? '0 : wpos_sum[WordPosW-1:0];
      if (word_done)
        widx_q <= widx_q + 1'b1;
      // Next instruction is picked up one cycle later
      if (issue_done_o)
        active_q <= 1'b0;
    end else if (!active_q && issue_valid_i) begin
      // Load the byte count of the new instruction
      active_q <= 1'b1;
      rem_q    <= issue_insn_i.vl << issue_insn_i.vew;
      wpos_q   <= '0;
      widx_q   <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (consume) begin
      data_q <= data_d;
      be_q   <= be_d;
    end
  end

endmodule

`default_nettype wire

/* src/vldu_result_queue.sv */
//////////////////////////////////////////////////////////////////////
// Result queue
// Holds complete VRF words until every lane has granted its part,
// then retires them and flags finished loads
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vldu_result_queue (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // From the beat unpacker
  input  logic                                       push_i,
  input  vldu_pkg::result_word_t                     push_word_i,
  output logic                                       full_o,
  // Lane write requests
  output logic               [vldu_pkg::NrLanes-1:0] lane_req_o,
  output vldu_pkg::lane_req_t [vldu_pkg::NrLanes-1:0] lane_o,
  output vldu_pkg::vid_t                             lane_id_o,
  input  logic               [vldu_pkg::NrLanes-1:0] lane_gnt_i,
  // Retirement and completion
  output logic                                       retire_last_o,
  output logic                                       load_complete_o,
  output vldu_pkg::vid_t                             done_id_o
);

  import vldu_pkg::*;

  // Word storage
  result_word_t [ResultQueueDepth-1:0] words_q;

  // Lanes still waiting for their grant, per entry
  logic [ResultQueueDepth-1:0][NrLanes-1:0] pend_q;

  logic [ResPtrW-1:0] wr_pnt_q;
  logic [ResPtrW-1:0] rd_pnt_q;
  logic [ResCntW-1:0] cnt_q;

  logic [NrLanes-1:0] pend_left;
  logic               retire;

  assign full_o = (cnt_q == ResCntW'(ResultQueueDepth));

  //////////////////////////////////////////////////////////////////////
  // Head word towards the lanes
  //////////////////////////////////////////////////////////////////////

  assign lane_req_o = pend_q[rd_pnt_q];
  assign lane_o     = words_q[rd_pnt_q].lanes;
  assign lane_id_o  = words_q[rd_pnt_q].id;

  // A grant without a request has no effect
  assign pend_left = pend_q[rd_pnt_q] & ~lane_gnt_i;

  // Retire in the cycle of the last outstanding grant
  assign retire        = (cnt_q != '0) && (pend_left == '0);
  assign retire_last_o = retire && words_q[rd_pnt_q].last;

  //////////////////////////////////////////////////////////////////////
  // Pointers, counts and completion
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q          <= '0;
      wr_pnt_q        <= '0;
      rd_pnt_q        <= '0;
      cnt_q           <= '0;
      load_complete_o <= 1'b0;
    end else begin
      pend_q[rd_pnt_q] <= pend_left;
      // New word requests every lane from the next cycle
      if (push_i) begin
        pend_q[wr_pnt_q] <= '1;
        wr_pnt_q         <= wr_pnt_q + 1'b1;
      end
      if (retire)
        rd_pnt_q <= rd_pnt_q + 1'b1;
      cnt_q <= cnt_q + ResCntW'(push_i) - ResCntW'(retire);
      // Pulse one cycle after the final word retires
      load_complete_o <= retire_last_o;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i)
      words_q[wr_pnt_q] <= push_word_i;
    if (retire_last_o)
      done_id_o <= words_q[rd_pnt_q].id;
  end

endmodule

`default_nettype wire

/* src/vldu_top.sv */
//////////////////////////////////////////////////////////////////////
// Vector load unit top
// Instruction queue, beat unpacker and lane result queue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vldu_top (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  // Instruction request
  input  vldu_pkg::load_insn_t                       insn_i,
  input  logic                                       insn_valid_i,
  output logic                                       insn_ready_o,
  // R channel
  input  vldu_pkg::beat_t                            r_data_i,
  input  logic                                       r_valid_i,
  output logic                                       r_ready_o,
  // Lanes
  output logic               [vldu_pkg::NrLanes-1:0] lane_req_o,
  output vldu_pkg::lane_req_t [vldu_pkg::NrLanes-1:0] lane_o,
  output vldu_pkg::vid_t                             lane_id_o,
  input  logic               [vldu_pkg::NrLanes-1:0] lane_gnt_i,
  // Completion
  output logic                                       load_complete_o,
  output vldu_pkg::vid_t                             done_id_o
);

  import vldu_pkg::*;

  load_insn_t   issue_insn;
  logic         issue_valid;
  logic         issue_done;
  logic         push;
  result_word_t push_word;
  logic         full;
  logic         retire_last;

  vldu_insn_queue i_insn_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .insn_i        (insn_i),
    .insn_valid_i  (insn_valid_i),
    .insn_ready_o  (insn_ready_o),
    .issue_insn_o  (issue_insn),
    .issue_valid_o (issue_valid),
    .issue_done_i  (issue_done),
    .retire_last_i (retire_last)
  );

  vldu_beat_unpack i_beat_unpack (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_insn_i  (issue_insn),
    .issue_valid_i (issue_valid),
    .issue_done_o  (issue_done),
    .r_data_i      (r_data_i),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .full_i        (full),
    .push_o        (push),
    .push_word_o   (push_word)
  );

  vldu_result_queue i_result_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .push_i          (push),
    .push_word_i     (push_word),
    .full_o          (full),
    .lane_req_o      (lane_req_o),
    .lane_o          (lane_o),
    .lane_id_o       (lane_id_o),
    .lane_gnt_i      (lane_gnt_i),
    .retire_last_o   (retire_last),
    .load_complete_o (load_complete_o),
    .done_id_o       (done_id_o)
  );

endmodule

`default_nettype wire

/* bench/vldu_chk.sv */
//////////////////////////////////////////////////////////////////////
// Result queue checks
// Lane requests hold until granted, no push into a full queue and
// completion pulses of one cycle per load
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vldu_chk (
  input logic                                        clk_i,
  input logic                                        rst_ni,
  input logic                                        push_i,
  input logic                                        full_o,
  input logic                [vldu_pkg::NrLanes-1:0] lane_req_o,
  input vldu_pkg::lane_req_t [vldu_pkg::NrLanes-1:0] lane_o,
  input logic                [vldu_pkg::NrLanes-1:0] lane_gnt_i,
  input logic                                        load_complete_o,
  input vldu_pkg::vid_t                              done_id_o
);

  import vldu_pkg::*;

  for (genvar l = 0; l < NrLanes; l++) begin : g_lane
    // Ungranted request keeps its word
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      lane_req_o[l] && !lane_gnt_i[l] |=> lane_req_o[l] && $stable(lane_o[l]))
      else $error("Lane %0d request changed before its grant", l);
  end

  assert property (@(posedge clk_i) disable iff (!rst_ni) !(push_i && full_o))
    else $error("Push into a full result queue");

  // Back to back pulses belong to two different loads
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    load_complete_o && $past(load_complete_o) |-> done_id_o != $past(done_id_o))
    else $error("Completion pulse held over two cycles for one load");

endmodule

bind vldu_result_queue vldu_chk i_chk (.*);

`default_nettype wire

/* bench/vldu_tb.sv */
//////////////////////////////////////////////////////////////////////
// Vector load unit testbench
// Pattern driven loads with LFSR beat data, a lane grant model and
// a reference model of the lane writes and the completions
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module vldu_tb;

  import vldu_pkg::*;

  localparam int NrInsn    = 10;
  localparam int PatFields = 5;
  localparam int MaxBeats  = NrInsn * 16;
  localparam int MaxWrites = NrInsn * VRegWords;

  // Expected write of one lane, with the id seen on lane_id_o
  typedef struct packed {
    vid_t      id;
    lane_req_t req;
  } lane_exp_t;

  // DUT connections
  logic                       clk_i;
  logic                       rst_ni;
  load_insn_t                 insn_i;
  logic                       insn_valid_i;
  logic                       insn_ready_o;
  beat_t                      r_data_i;
  logic                       r_valid_i;
  logic                       r_ready_o;
  logic      [NrLanes-1:0]    lane_req_o;
  lane_req_t [NrLanes-1:0]    lane_o;
  vid_t                       lane_id_o;
  logic      [NrLanes-1:0]    lane_gnt_i;
  logic                       load_complete_o;
  vid_t                       done_id_o;

  // Pattern file contents and per load data
  logic [7:0] pat_mem [0:NrInsn*PatFields-1];
  load_insn_t insn_pat [0:NrInsn-1];
  int         stall_pat [0:NrInsn-1];
  int         words_pat [0:NrInsn-1];

  // Lane grant delay and open lane writes, looked up by id
  int stall_by_id [0:7];
  int pend_by_id [0:7];
  int lane_wait [0:NrLanes-1];

  // Reference model output
  beat_t     beat_mem [0:MaxBeats-1];
  lane_exp_t exp_mem [0:NrLanes-1][0:MaxWrites-1];
  int        exp_wr [0:NrLanes-1];
  int        exp_rd [0:NrLanes-1];
  int        n_beats;
  int        beat_rd;
  int        insn_rd;
  int        done_rd;

  int          n_checks;
  int          n_errors;
  int          cycle_cnt;
  int          cycle_limit;
  logic        ready_low_seen;
  logic        r_stall_seen;
  logic [15:0] lfsr;

  vldu_top dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic compare(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
    n_checks++;
    if (expected !== actual) begin
      n_errors++;
      $display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per data bit
  task automatic rand_byte(output logic [7:0] b);
    b = '0;
    for (int k = 0; k < 8; k++) begin
      lfsr = lfsr_step(lfsr);
      b    = {b[6:0], lfsr[0]};
    end
  endtask

  // Beats and expected lane writes of load i
  task automatic build_model(input int i);
    logic [7:0] stream [0:127];
    logic [7:0] rb;
    lane_exp_t  e;
    int         bytes;
    int         esize;
    int         beats;
    int         words;
    int         idx;
    int         elem;
    int         lane;
    int         lbyte;
    esize        = 1 << insn_pat[i].vew;
    bytes        = int'(insn_pat[i].vl) * esize;
    beats        = (bytes + BeatBytes - 1) / BeatBytes;
    words        = (bytes + WordBytes - 1) / WordBytes;
    words_pat[i] = words;
    cycle_limit += 2 * beats + 2 * words * (stall_pat[i] + 2);
    // Every load opens a fresh beat, tail bytes of a beat are unused
    for (int k = 0; k < beats; k++) begin
      for (int j = 0; j < BeatBytes; j++) begin
        rand_byte(rb);
        stream[k*BeatBytes+j]       = rb;
        beat_mem[n_beats][8*j +: 8] = rb;
      end
      n_beats++;
    end
    for (int w = 0; w < words; w++) begin
      for (int l = 0; l < NrLanes; l++) begin
        e          = '0;
        e.id       = insn_pat[i].id;
        e.req.addr = vaddr_t'(int'(insn_pat[i].vd) * VRegWords + w);
        for (int b = 0; b < WordBytes; b++) begin
          // Element shuffle within the VRF word
          idx   = w * WordBytes + b;
          elem  = b / esize;
          lane  = elem % NrLanes;
          lbyte = (elem / NrLanes) * esize + b % esize;
          if (lane == l && idx < bytes) begin
            e.req.wdata[8*lbyte +: 8] = stream[idx];
            e.req.be[lbyte]           = 1'b1;
          end
        end
        exp_mem[l][exp_wr[l]] = e;
        exp_wr[l]++;
      end
    end
  endtask

  task automatic check_write(input int l);
    if (exp_rd[l] >= exp_wr[l]) begin
      n_errors++;
      $display("Lane %0d was granted a write that the model does not expect", l);
    end else begin
      compare($sformatf("lane%0d write %0d", l, exp_rd[l]), exp_mem[l][exp_rd[l]],
              {lane_id_o, lane_o[l]});
      pend_by_id[exp_mem[l][exp_rd[l]].id]--;
      exp_rd[l]++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Per cycle stimulus and checks, run on the falling edge
  //////////////////////////////////////////////////////////////////////

  task automatic step_cycle();
    // Completions in acceptance order, after every lane write of the load
    if (load_complete_o) begin
      if (done_rd >= NrInsn) begin
        n_errors++;
        $display("Completion pulse seen with no load outstanding");
      end else begin
        compare($sformatf("done id %0d", done_rd), insn_pat[done_rd].id, done_id_o);
        compare($sformatf("writes left at done %0d", done_rd), 0,
                pend_by_id[insn_pat[done_rd].id]);
        done_rd++;
      end
    end
    // At most four loads between acceptance and completion
    compare($sformatf("insn ready cycle %0d", cycle_cnt),
            (insn_rd - done_rd) < InsnQueueDepth, insn_ready_o);
    // Ready only depends on DUT state, so it holds until the rising edge
    if (insn_rd < NrInsn) begin
      insn_valid_i = 1'b1;
      insn_i       = insn_pat[insn_rd];
      if (insn_ready_o) begin
        stall_by_id[insn_pat[insn_rd].id] = stall_pat[insn_rd];
        pend_by_id[insn_pat[insn_rd].id] += NrLanes * words_pat[insn_rd];
        insn_rd++;
      end else begin
        ready_low_seen = 1'b1;
      end
    end else begin
      insn_valid_i = 1'b0;
    end
    // R beats with a short valid gap now and then
    if (beat_rd < n_beats && (cycle_cnt % 7) != 3) begin
      r_valid_i = 1'b1;
      r_data_i  = beat_mem[beat_rd];
      if (r_ready_o)
        beat_rd++;
      else if (dut.i_result_queue.full_o)
        r_stall_seen = 1'b1;
    end else begin
      r_valid_i = 1'b0;
    end
    // Lane grants after the stall count of the head word
    for (int l = 0; l < NrLanes; l++) begin
      lane_gnt_i[l] = 1'b0;
      if (!lane_req_o[l]) begin
        lane_wait[l] = 0;
      end else if (lane_wait[l] < stall_by_id[lane_id_o]) begin
        lane_wait[l]++;
      end else begin
        lane_gnt_i[l] = 1'b1;
        lane_wait[l]  = 0;
        check_write(l);
      end
    end
  endtask

  task automatic end_run();
    $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_ni       = 1'b0;
    insn_i       = '0;
    insn_valid_i = 1'b0;
    r_data_i     = '0;
    r_valid_i    = 1'b0;
    lane_gnt_i   = '0;
    n_checks     = 0;
    n_errors     = 0;
    cycle_cnt    = 0;
    cycle_limit  = 100;
    n_beats      = 0;
    beat_rd      = 0;
    insn_rd      = 0;
    done_rd      = 0;
    lfsr         = 16'd76;
    ready_low_seen = 1'b0;
    r_stall_seen   = 1'b0;
    for (int l = 0; l < NrLanes; l++) begin
      exp_wr[l]    = 0;
      exp_rd[l]    = 0;
      lane_wait[l] = 0;
    end
    for (int k = 0; k < 8; k++) begin
      stall_by_id[k] = 0;
      pend_by_id[k]  = 0;
    end
    $readmemh("bench/vldu_patterns.txt", pat_mem);
    for (int k = 0; k < NrInsn * PatFields; k++) begin
      if ($isunknown(pat_mem[k])) begin
        n_errors++;
        $display("Pattern file is missing or short at field %0d", k);
      end
    end
    for (int i = 0; i < NrInsn; i++) begin
      insn_pat[i].id  = vid_t'(pat_mem[PatFields*i]);
      insn_pat[i].vd  = vreg_t'(pat_mem[PatFields*i+1]);
      insn_pat[i].vew = vew_e'(pat_mem[PatFields*i+2]);
      insn_pat[i].vl  = pat_mem[PatFields*i+3];
      stall_pat[i]    = int'(pat_mem[PatFields*i+4]);
      build_model(i);
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    // Until every load has completed and every lane write arrived
    while (done_rd < NrInsn || exp_rd[0] < exp_wr[0] || exp_rd[1] < exp_wr[1]) begin
      @(negedge clk_i);
      step_cycle();
    end
    // A few idle cycles to catch stray grants or pulses
    repeat (5) begin
      @(negedge clk_i);
      step_cycle();
    end
    if (!ready_low_seen) begin
      n_errors++;
      $display("Instruction ready never dropped with four loads in flight");
    end
    if (!r_stall_seen) begin
      n_errors++;
      $display("R ready never dropped while the result queue was full");
    end
    end_run();
  end

  initial begin : watchdog
    @(posedge rst_ni);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    n_errors++;
    $display("Timeout after %0d cycles, %0d of %0d loads completed",
             cycle_cnt, done_rd, NrInsn);
    end_run();
  end

endmodule

`default_nettype wire

/* bench/vldu_patterns.txt */
// Load instructions, one per line, all fields hex
// id  vd  ew(0=8b 1=16b 2=32b 3=64b)  vl  lane stall cycles
0 01 3 08 02  // 64 bytes, whole 64-bit elements
1 02 3 10 03  // 128 bytes, fills the register
2 03 0 20 01  // 32 bytes of bytes
3 04 1 18 02  // 48 bytes of halfwords
4 05 2 0c 08  // long grant stall
5 06 0 0b 00  // 11 bytes, ends inside a beat
6 07 1 0d 01  // 26 bytes, partial last word
7 1f 2 05 06  // top register
0 0a 3 03 00  // id reused once the first load is done
1 10 0 80 02  // 128 single bytes

/* all.f */
src/vldu_pkg.sv
src/vldu_insn_queue.sv
src/vldu_beat_unpack.sv
src/vldu_result_queue.sv
src/vldu_top.sv
bench/vldu_chk.sv
bench/vldu_tb.sv
